/* rtl/hwpf_defs.svh */
// address split, training table size and descriptor queue depth of the stride prefetcher
`ifndef HWPF_DEFS_SVH
`define HWPF_DEFS_SVH

// snoop address width in bits
`define HWPF_ADDR_W 49

// byte offset within a cache line
`define HWPF_OFS_W 4

// line index within a region, address bits 9 to 4
`define HWPF_IDX_W 6

// region tag, address bits 48 to 10
`define HWPF_TAG_W 39

// line address, address bits 48 to 4
`define HWPF_LINE_W 45

// fully associative training entries
`define HWPF_TABLE_SIZE 8

// descriptor FIFO entries
`define HWPF_QUEUE_DEPTH 16

`endif

/* rtl/hwpf_pkg.sv */
// training state enum and address field types of the stride prefetcher
`include "hwpf_defs.svh"

package hwpf_pkg;

    // per-region training sequence, HIT3 confirms and emits
    typedef enum logic [2:0] {
        INITIAL,
        STRIDE_DETECTION,
        HIT1,
        HIT2,
        HIT3
    } train_state_e;

    // upper address bits that name a region
    typedef logic [`HWPF_TAG_W-1:0] region_tag_t;

    // line position inside a region
    typedef logic [`HWPF_IDX_W-1:0] line_idx_t;

    // line stride, wraps modulo 64 like the index it is computed from
    typedef logic signed [`HWPF_IDX_W-1:0] stride_t;

    // cache line address, byte offset removed
    typedef logic [`HWPF_LINE_W-1:0] line_addr_t;

endpackage

/* rtl/snoop_capture.sv */
// snoop input stage: filters idle and zero-tag accesses, registers and splits the address
`timescale 1ns/1ps
`include "hwpf_defs.svh"

module snoop_capture import hwpf_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    snoop_valid_i,
    input  logic [`HWPF_ADDR_W-1:0] snoop_addr_i,
    output logic                    cap_valid_o,
    output region_tag_t             cap_tag_o,
    output line_idx_t               cap_idx_o,
    output line_addr_t              cap_line_o
);

    region_tag_t snoop_tag;
    logic        accept;

    // idle ports show zero addresses, so a zero tag never trains
    assign snoop_tag = snoop_addr_i[`HWPF_ADDR_W-1 -: `HWPF_TAG_W];
    assign accept    = snoop_valid_i && (snoop_tag != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            cap_valid_o <= 1'b0;
        end else begin
            cap_valid_o <= accept;
        end
    end

    // address fields only load on an accepted access
    always_ff @(posedge clk_i) begin
        if (accept) begin
            cap_tag_o  <= snoop_tag;
            cap_idx_o  <= snoop_addr_i[`HWPF_OFS_W +: `HWPF_IDX_W];
            cap_line_o <= snoop_addr_i[`HWPF_ADDR_W-1:`HWPF_OFS_W];
        end
    end

endmodule

/* rtl/stride_table.sv */
// fully associative training table with LRU ages, stride training FSM and emission register
`timescale 1ns/1ps
`include "hwpf_defs.svh"

module stride_table import hwpf_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        cap_valid_i,
    input  region_tag_t cap_tag_i,
    input  line_idx_t   cap_idx_i,
    input  line_addr_t  cap_line_i,
    output logic        emit_valid_o,
    output line_addr_t  emit_base_o,
    output stride_t     emit_stride_o
);

    localparam int AGE_W = $clog2(`HWPF_TABLE_SIZE);

    // an age doubles as an entry number, both range over the table
    typedef logic [AGE_W-1:0] ent_t;

    // entry storage
    logic [`HWPF_TABLE_SIZE-1:0] valid_q;
    ent_t                        age_q      [`HWPF_TABLE_SIZE];
    region_tag_t                 tag_q      [`HWPF_TABLE_SIZE];
    line_idx_t                   last_idx_q [`HWPF_TABLE_SIZE];
    stride_t                     stride_q   [`HWPF_TABLE_SIZE];
    train_state_e                state_q    [`HWPF_TABLE_SIZE];

    // lookup results
    logic         hit;
    ent_t         hit_idx;
    logic         any_inv;
    ent_t         inv_idx;
    ent_t         lru_idx;
    ent_t         sel;

    // training datapath of the selected entry
    line_idx_t    cur_idx;
    stride_t      cur_stride;
    train_state_e cur_state;
    line_idx_t    idx_pred;
    stride_t      new_stride;
    logic         stride_ok;
    logic         do_alloc;
    logic         do_train;
    logic         do_emit;
    train_state_e nxt_state;
    stride_t      nxt_stride;

    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        any_inv = 1'b0;
        inv_idx = '0;
        lru_idx = '0;
        for (int i = 0; i < `HWPF_TABLE_SIZE; i++) begin
            if (!hit && valid_q[i] && (tag_q[i] == cap_tag_i)) begin
                hit     = 1'b1;
                hit_idx = ent_t'(i);
            end
            // lowest-numbered free entry wins
            if (!any_inv && !valid_q[i]) begin
                any_inv = 1'b1;
                inv_idx = ent_t'(i);
            end
            if (age_q[i] == ent_t'(`HWPF_TABLE_SIZE - 1)) begin
                lru_idx = ent_t'(i);
            end
        end
        if (hit) begin
            sel = hit_idx;
        end else if (any_inv) begin
            sel = inv_idx;
        end else begin
            sel = lru_idx;
        end
    end

    assign cur_idx    = last_idx_q[sel];
    assign cur_stride = stride_q[sel];
    assign cur_state  = state_q[sel];
    assign idx_pred   = cur_idx + line_idx_t'(cur_stride);
    assign new_stride = stride_t'(cap_idx_i - cur_idx);
    assign stride_ok  = (idx_pred == cap_idx_i);

    // a repeated index on a hit leaves the training alone
    assign do_alloc = cap_valid_i && !hit;
    assign do_train = cap_valid_i && hit && (cap_idx_i != cur_idx);

    always_comb begin
        nxt_state  = cur_state;
        nxt_stride = cur_stride;
        do_emit    = 1'b0;
        if (do_alloc) begin
            nxt_state  = INITIAL;
            nxt_stride = '0;
        end else if (do_train) begin
            if (cur_state == INITIAL || !stride_ok) begin
                // first delta, or a broken pattern, restarts from the new stride
                nxt_stride = new_stride;
                nxt_state  = (cur_state == INITIAL) ? STRIDE_DETECTION : INITIAL;
            end else begin
                case (cur_state)
                    STRIDE_DETECTION: nxt_state = HIT1;
                    HIT1:             nxt_state = HIT2;
                    HIT2:             nxt_state = HIT3;
                    HIT3: begin
                        nxt_state = INITIAL;
                        do_emit   = 1'b1;
                    end
                    default:          nxt_state = INITIAL;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q      <= '0;
            emit_valid_o <= 1'b0;
            for (int i = 0; i < `HWPF_TABLE_SIZE; i++) begin
                age_q[i] <= ent_t'(i);
            end
        end else begin
            emit_valid_o <= do_emit;
            if (cap_valid_i) begin
                // move the touched entry to most recent, age the younger ones
                for (int k = 0; k < `HWPF_TABLE_SIZE; k++) begin
                    if (age_q[k] < age_q[sel]) begin
                        age_q[k] <= age_q[k] + 1'b1;
                    end
                end
                age_q[sel] <= '0;
            end
            if (do_alloc) begin
                valid_q[sel] <= 1'b1;
            end
            // a confirmed stream frees its entry, ages stay put
            if (do_emit) begin
                valid_q[sel] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_alloc || do_train) begin
            tag_q[sel]      <= cap_tag_i;
            last_idx_q[sel] <= cap_idx_i;
            stride_q[sel]   <= nxt_stride;
            state_q[sel]    <= nxt_state;
        end
        if (do_emit) begin
            emit_base_o   <= cap_line_i +
                             {{(`HWPF_LINE_W - `HWPF_IDX_W){cur_stride[`HWPF_IDX_W-1]}},
                              cur_stride};
            emit_stride_o <= cur_stride;
        end
    end

endmodule

/* rtl/stream_queue.sv */
// descriptor FIFO with valid/ready output, drops and flags emissions that find it full
`timescale 1ns/1ps
`include "hwpf_defs.svh"

module stream_queue import hwpf_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       emit_valid_i,
    input  line_addr_t emit_base_i,
    input  stride_t    emit_stride_i,
    output logic       pf_valid_o,
    input  logic       pf_ready_i,
    output line_addr_t pf_base_line_o,
    output stride_t    pf_stride_o,
    output logic       pf_drop_o
);

    localparam int PTR_W = $clog2(`HWPF_QUEUE_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;

    line_addr_t     base_mem   [`HWPF_QUEUE_DEPTH];
    stride_t        stride_mem [`HWPF_QUEUE_DEPTH];
    ptr_t           head_q;
    ptr_t           tail_q;
    logic [PTR_W:0] count_q;
    logic           full;
    logic           push;
    logic           pop;

    assign full = (count_q == (PTR_W+1)'(`HWPF_QUEUE_DEPTH));
    assign pop  = pf_valid_o && pf_ready_i;
    // a pop on the same edge frees the slot a full queue needs
    assign push = emit_valid_i && (!full || pop);

    assign pf_valid_o     = (count_q != '0);
    assign pf_base_line_o = base_mem[head_q];
    assign pf_stride_o    = stride_mem[head_q];

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            head_q    <= '0;
            tail_q    <= '0;
            count_q   <= '0;
            pf_drop_o <= 1'b0;
        end else begin
            pf_drop_o <= emit_valid_i && !push;
            // pointers wrap by overflow, depth is a power of two
            if (push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            base_mem[tail_q]   <= emit_base_i;
            stride_mem[tail_q] <= emit_stride_i;
        end
    end

endmodule

/* rtl/stride_prefetcher_top.sv */
// stride prefetcher front end: snoop capture, training table and descriptor queue in a chain
`timescale 1ns/1ps
`include "hwpf_defs.svh"

module stride_prefetcher_top import hwpf_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    snoop_valid_i,
    input  logic [`HWPF_ADDR_W-1:0] snoop_addr_i,
    output logic                    pf_valid_o,
    input  logic                    pf_ready_i,
    output line_addr_t              pf_base_line_o,
    output stride_t                 pf_stride_o,
    output logic                    pf_drop_o
);

    // capture to table
    logic        cap_valid;
    region_tag_t cap_tag;
    line_idx_t   cap_idx;
    line_addr_t  cap_line;

    // table to queue, single-cycle pulses
    logic        emit_valid;
    line_addr_t  emit_base;
    stride_t     emit_stride;

    snoop_capture u_capture (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .snoop_valid_i (snoop_valid_i),
        .snoop_addr_i  (snoop_addr_i),
        .cap_valid_o   (cap_valid),
        .cap_tag_o     (cap_tag),
        .cap_idx_o     (cap_idx),
        .cap_line_o    (cap_line)
    );

    stride_table u_table (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cap_valid_i   (cap_valid),
        .cap_tag_i     (cap_tag),
        .cap_idx_i     (cap_idx),
        .cap_line_i    (cap_line),
        .emit_valid_o  (emit_valid),
        .emit_base_o   (emit_base),
        .emit_stride_o (emit_stride)
    );

    stream_queue u_queue (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .emit_valid_i   (emit_valid),
        .emit_base_i    (emit_base),
        .emit_stride_i  (emit_stride),
        .pf_valid_o     (pf_valid_o),
        .pf_ready_i     (pf_ready_i),
        .pf_base_line_o (pf_base_line_o),
        .pf_stride_o    (pf_stride_o),
        .pf_drop_o      (pf_drop_o)
    );

endmodule

/* tb/stride_prefetcher_assertions.sv */
// concurrent checks on descriptor handshake, drop flag and table tag uniqueness, with its bind
`timescale 1ns/1ps
`include "hwpf_defs.svh"

module stride_prefetcher_assertions import hwpf_pkg::*; (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                pf_valid_i,
    input  logic                                pf_ready_i,
    input  line_addr_t                          pf_base_i,
    input  stride_t                             pf_stride_i,
    input  logic                                pf_drop_i,
    input  logic [$clog2(`HWPF_QUEUE_DEPTH):0]  count_i,
    input  logic [`HWPF_TABLE_SIZE-1:0]         valid_i,
    input  region_tag_t                         tag_i [`HWPF_TABLE_SIZE]
);

    int   err_cnt = 0;
    logic dup_tag;

    // two live entries for one region would split its training
    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < `HWPF_TABLE_SIZE; i++) begin
            for (int j = i + 1; j < `HWPF_TABLE_SIZE; j++) begin
                if (valid_i[i] && valid_i[j] && (tag_i[i] == tag_i[j])) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pf_valid_i && !pf_ready_i |=> pf_valid_i && $stable(pf_base_i) && $stable(pf_stride_i))
    else begin
        $error("descriptor changed or vanished before it was accepted");
        err_cnt++;
    end

    // the drop flag is registered, so the queue was full one edge earlier
    drop_on_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pf_drop_i |-> $past(count_i) == `HWPF_QUEUE_DEPTH)
    else begin
        $error("descriptor dropped while the queue had room");
        err_cnt++;
    end

    unique_tags: assert property (@(posedge clk_i) disable iff (!rst_ni) !dup_tag)
    else begin
        $error("two valid table entries hold the same region tag");
        err_cnt++;
    end

endmodule

bind stride_prefetcher_top stride_prefetcher_assertions u_asrt (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pf_valid_i  (u_queue.pf_valid_o),
    .pf_ready_i  (u_queue.pf_ready_i),
    .pf_base_i   (u_queue.pf_base_line_o),
    .pf_stride_i (u_queue.pf_stride_o),
    .pf_drop_i   (u_queue.pf_drop_o),
    .count_i     (u_queue.count_q),
    .valid_i     (u_table.valid_q),
    .tag_i       (u_table.tag_q)
);

/* tb/stride_prefetcher_tb.sv */
// testbench with clock, reset, directed and random snoop streams, table model and descriptor compare
`timescale 1ns/1ps
`include "hwpf_defs.svh"

module stride_prefetcher_tb import hwpf_pkg::*; ();

    // upper bound on the accesses driven over all tests
    localparam int MAX_ACCESSES = 470;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    snoop_valid;
    logic [`HWPF_ADDR_W-1:0] snoop_addr;
    logic                    pf_valid;
    logic                    pf_ready;
    line_addr_t              pf_base;
    stride_t                 pf_stride;
    logic                    pf_drop;

    // reference table where state 0 is INITIAL and 4 is HIT3
    logic        m_valid  [`HWPF_TABLE_SIZE];
    region_tag_t m_tag    [`HWPF_TABLE_SIZE];
    line_idx_t   m_idx    [`HWPF_TABLE_SIZE];
    stride_t     m_stride [`HWPF_TABLE_SIZE];
    int          m_state  [`HWPF_TABLE_SIZE];
    int          m_age    [`HWPF_TABLE_SIZE];

    line_addr_t  exp_base   [$];
    stride_t     exp_stride [$];
    string       test_name;
    int          errors = 0;
    int          err_at_start;
    int          tests = 0;
    int          q_limit = 1 << 30;
    int          drops_exp = 0;
    int          drops_seen = 0;
    int          ready_mode = 0;

    stride_prefetcher_top u_dut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .snoop_valid_i  (snoop_valid),
        .snoop_addr_i   (snoop_addr),
        .pf_valid_o     (pf_valid),
        .pf_ready_i     (pf_ready),
        .pf_base_line_o (pf_base),
        .pf_stride_o    (pf_stride),
        .pf_drop_o      (pf_drop)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic compare_val(input string what, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
            errors++;
        end
    endtask

    // returns 1 when the access confirms a stride in HIT3
    function automatic bit model_access(input region_tag_t tag, input line_idx_t idx,
                                        output line_addr_t base, output stride_t stride);
        int s;
        int old_age;
        bit hit;
        bit emit;
        s = -1;
        emit = 1'b0;
        base = '0;
        stride = '0;
        for (int i = 0; i < `HWPF_TABLE_SIZE; i++) begin
            if (s < 0 && m_valid[i] && m_tag[i] == tag) s = i;
        end
        hit = (s >= 0);
        for (int i = 0; i < `HWPF_TABLE_SIZE; i++) begin
            if (s < 0 && !m_valid[i]) s = i;
        end
        for (int i = 0; i < `HWPF_TABLE_SIZE; i++) begin
            if (s < 0 && m_age[i] == `HWPF_TABLE_SIZE - 1) s = i;
        end
        old_age = m_age[s];
        for (int i = 0; i < `HWPF_TABLE_SIZE; i++) begin
            if (m_age[i] < old_age) m_age[i]++;
        end
        m_age[s] = 0;
        if (!hit) begin
            m_valid[s]  = 1'b1;
            m_tag[s]    = tag;
            m_idx[s]    = idx;
            m_stride[s] = '0;
            m_state[s]  = 0;
        end else if (idx != m_idx[s]) begin
            if (m_state[s] != 0 && line_idx_t'(m_idx[s] + m_stride[s]) == idx) begin
                if (m_state[s] == 4) begin
                    emit = 1'b1;
                    stride = m_stride[s];
                    base = line_addr_t'(longint'({tag, idx}) + longint'(m_stride[s]));
                    m_valid[s] = 1'b0;
                    m_state[s] = 0;
                end else begin
                    m_state[s]++;
                end
            end else begin
                m_state[s]  = (m_state[s] == 0) ? 1 : 0;
                m_stride[s] = stride_t'(idx - m_idx[s]);
            end
            m_idx[s] = idx;
        end
        return emit;
    endfunction

    task automatic access(input bit valid, input region_tag_t tag, input line_idx_t idx);
        line_addr_t base;
        stride_t    stride;
        @(posedge clk_i);
        #2;
        snoop_valid = valid;
        snoop_addr  = {tag, idx, 4'($urandom_range(0, 15))};
        if (valid && tag != '0) begin
            if (model_access(tag, idx, base, stride)) begin
                // a full queue loses the descriptor
                if (exp_base.size() < q_limit) begin
                    exp_base.push_back(base);
                    exp_stride.push_back(stride);
                end else begin
                    drops_exp++;
                end
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #2;
            snoop_valid = 1'b0;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_at_start = errors;
    endtask

    task automatic end_test();
        idle(1);
        while (exp_base.size() != 0) @(posedge clk_i);
        repeat (6) @(posedge clk_i);
        tests++;
        $display("test %s: done, %0d mismatches", test_name, errors - err_at_start);
    endtask

    task automatic random_streams(input int n);
        region_tag_t tags [4];
        line_idx_t   pos  [4];
        stride_t     step [4];
        int          r;
        for (int i = 0; i < 4; i++) begin
            tags[i] = region_tag_t'({$urandom, $urandom}) | 39'h400;
            pos[i]  = line_idx_t'($urandom);
            step[i] = stride_t'($urandom_range(1, 3));
        end
        for (int k = 0; k < n; k++) begin
            r = $urandom_range(0, 3);
            if ($urandom_range(0, 9) == 0) step[r] = stride_t'($urandom);
            pos[r] = pos[r] + line_idx_t'(step[r]);
            access(1'b1, tags[r], pos[r]);
            idle($urandom_range(0, 2));
        end
    endtask

    // mode 0 keeps ready high, mode 1 holds it low and any other mode randomizes it
    always @(posedge clk_i) begin
        #2;
        if (ready_mode == 0) pf_ready = 1'b1;
        else if (ready_mode == 1) pf_ready = 1'b0;
        else pf_ready = $urandom_range(0, 1);
    end

    // valid and ready seen high mid-cycle transfer on the next rising edge
    always @(negedge clk_i) begin
        if (rst_ni && pf_drop) drops_seen++;
        if (rst_ni && pf_valid && pf_ready) begin
            if (exp_base.size() == 0) begin
                $display("test %s: descriptor %h came out with none predicted", test_name, pf_base);
                errors++;
            end else begin
                compare_val("base", exp_base.pop_front(), pf_base);
                compare_val("stride", exp_stride.pop_front(), pf_stride);
            end
        end
    end

    initial begin
        repeat (MAX_ACCESSES * 40 + 400) @(posedge clk_i);
        $display("timeout: the run did not finish within the expected number of cycles");
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h1c3f_fe13));
        rst_ni      = 1'b0;
        snoop_valid = 1'b0;
        snoop_addr  = '0;
        pf_ready    = 1'b1;
        for (int i = 0; i < `HWPF_TABLE_SIZE; i++) begin
            m_valid[i] = 1'b0;
            m_age[i]   = i;
        end
        repeat (16) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        begin_test("stride_up");
        for (int k = 1; k <= 12; k++) access(1'b1, 39'h1000, line_idx_t'(k));
        end_test();

        begin_test("stride_down");
        for (int k = 40; k >= 30; k -= 2) access(1'b1, 39'h2000, line_idx_t'(k));
        end_test();

        begin_test("restart_and_filter");
        for (int k = 1; k <= 3; k++) access(1'b1, 39'h3000, line_idx_t'(k));
        access(1'b1, 39'h3000, 6'd3);
        access(1'b1, 39'h3000, 6'd9);
        for (int k = 11; k <= 15; k += 2) access(1'b1, 39'h3000, line_idx_t'(k));
        // if taken this access would break the stride in HIT2
        access(1'b0, 39'h3000, 6'd40);
        for (int k = 17; k <= 21; k += 2) access(1'b1, 39'h3000, line_idx_t'(k));
        // a stride run that would confirm and emit if zero tags were accepted
        for (int k = 1; k <= 6; k++) access(1'b1, '0, line_idx_t'(k));
        end_test();

        begin_test("lru_eviction");
        for (int k = 1; k <= 2; k++) begin
            for (int r = 0; r < 8; r++) access(1'b1, region_tag_t'(100 + r), line_idx_t'(k));
        end
        access(1'b1, region_tag_t'(108), 6'd1);
        for (int k = 3; k <= 8; k++) access(1'b1, region_tag_t'(100), line_idx_t'(k));
        end_test();

        begin_test("backpressure_drop");
        ready_mode = 1;
        q_limit    = `HWPF_QUEUE_DEPTH;
        drops_exp  = 0;
        drops_seen = 0;
        repeat (2) @(posedge clk_i);
        for (int k = 0; k < 108; k++) access(1'b1, 39'h5_5000, line_idx_t'(k));
        idle(1);
        repeat (4) @(posedge clk_i);
        compare_val("drops", drops_exp, drops_seen);
        ready_mode = 0;
        q_limit    = 1 << 30;
        end_test();

        begin_test("random_streams");
        ready_mode = 2;
        random_streams(300);
        end_test();

        $display("tests run %0d, mismatches %0d, assertion failures %0d",
                 tests, errors, u_dut.u_asrt.err_cnt);
        if (errors + u_dut.u_asrt.err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+rtl
rtl/hwpf_pkg.sv
rtl/snoop_capture.sv
rtl/stride_table.sv
rtl/stream_queue.sv
rtl/stride_prefetcher_top.sv
tb/stride_prefetcher_assertions.sv
tb/stride_prefetcher_tb.sv
